// ==== include/mp_defines.svh ====
`ifndef MP_DEFINES_SVH
`define MP_DEFINES_SVH

// Word and address widths
`define MP_WIDTH      16
`define MP_BANK_BITS  2
`define MP_ROW_BITS   4

// Bank and port counts
`define MP_NUM_BANKS  4
`define MP_NUM_WR     2
`define MP_NUM_RD     2

// Bank read pipeline depth including the array read
`define MP_SRAM_DELAY 2

// Request sample edge to response edge
`define MP_RD_LATENCY 4

`endif

// ==== rtl/mp_pkg.sv ====
`include "mp_defines.svh"

package mp_pkg;

  typedef logic [`MP_WIDTH-1:0]                 data_t;
  typedef logic [`MP_BANK_BITS-1:0]             bank_t;
  typedef logic [`MP_ROW_BITS-1:0]              row_t;
  // Bank sits above row
  typedef logic [`MP_BANK_BITS+`MP_ROW_BITS-1:0] paddr_t;

  typedef struct packed {
    logic  vld;
    bank_t bank;
    row_t  row;
    data_t data;
  } wr_req_t;

  typedef struct packed {
    logic  vld;
    bank_t bank;
    row_t  row;
  } rd_req_t;

  // Registered per-bank command after arbitration
  typedef struct packed {
    logic  wr;
    row_t  wr_row;
    data_t wr_data;
    logic  rd;
    row_t  rd_row;
  } bank_cmd_t;

  typedef struct packed {
    logic   vld;
    paddr_t padr;
  } rd_tag_t;

  typedef struct packed {
    logic   vld;
    paddr_t padr;
    data_t  data;
  } rd_resp_t;

endpackage

// ==== rtl/bank_arbiter.sv ====
`timescale 1ns/1ps
`include "mp_defines.svh"

module bank_arbiter
  import mp_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  wr_req_t   wr_req   [`MP_NUM_WR],
  input  rd_req_t   rd_req   [`MP_NUM_RD],
  output bank_cmd_t bank_cmd [`MP_NUM_BANKS],
  output rd_tag_t   rd_tag   [`MP_NUM_RD]
);

  bank_cmd_t                cmd_d     [`MP_NUM_BANKS];
  logic [`MP_NUM_BANKS-1:0] wr_q;
  logic [`MP_NUM_BANKS-1:0] rd_q;
  row_t                     wr_row_q  [`MP_NUM_BANKS];
  data_t                    wr_data_q [`MP_NUM_BANKS];
  row_t                     rd_row_q  [`MP_NUM_BANKS];
  logic [`MP_NUM_RD-1:0]    won;
  logic [`MP_NUM_RD-1:0]    tag_vld_q;
  paddr_t                   tag_padr_q [`MP_NUM_RD];

  // Ascending scan so the highest-numbered port overrides the others
  always_comb begin
    for (int b = 0; b < `MP_NUM_BANKS; b++) begin
      cmd_d[b] = '0;
      for (int w = 0; w < `MP_NUM_WR; w++) begin
        if (wr_req[w].vld && wr_req[w].bank == bank_t'(b)) begin
          cmd_d[b].wr      = 1'b1;
          cmd_d[b].wr_row  = wr_req[w].row;
          cmd_d[b].wr_data = wr_req[w].data;
        end
      end
      for (int r = 0; r < `MP_NUM_RD; r++) begin
        if (rd_req[r].vld && rd_req[r].bank == bank_t'(b)) begin
          cmd_d[b].rd     = 1'b1;
          cmd_d[b].rd_row = rd_req[r].row;
        end
      end
    end
  end

  // A read port loses if any higher port hits the same bank
  always_comb begin
    for (int p = 0; p < `MP_NUM_RD; p++) begin
      won[p] = rd_req[p].vld;
      for (int q = p + 1; q < `MP_NUM_RD; q++) begin
        if (rd_req[q].vld && rd_req[q].bank == rd_req[p].bank) begin
          won[p] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_q      <= '0;
      rd_q      <= '0;
      tag_vld_q <= '0;
    end else begin
      for (int b = 0; b < `MP_NUM_BANKS; b++) begin
        wr_q[b] <= cmd_d[b].wr;
        rd_q[b] <= cmd_d[b].rd;
      end
      tag_vld_q <= won;
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < `MP_NUM_BANKS; b++) begin
      wr_row_q[b]  <= cmd_d[b].wr_row;
      wr_data_q[b] <= cmd_d[b].wr_data;
      rd_row_q[b]  <= cmd_d[b].rd_row;
    end
    for (int p = 0; p < `MP_NUM_RD; p++) begin
      tag_padr_q[p] <= {rd_req[p].bank, rd_req[p].row};
    end
  end

  always_comb begin
    for (int b = 0; b < `MP_NUM_BANKS; b++) begin
      bank_cmd[b].wr      = wr_q[b];
      bank_cmd[b].wr_row  = wr_row_q[b];
      bank_cmd[b].wr_data = wr_data_q[b];
      bank_cmd[b].rd      = rd_q[b];
      bank_cmd[b].rd_row  = rd_row_q[b];
    end
    for (int p = 0; p < `MP_NUM_RD; p++) begin
      rd_tag[p].vld  = tag_vld_q[p];
      rd_tag[p].padr = tag_padr_q[p];
    end
  end

endmodule

// ==== rtl/bank_sram.sv ====
`timescale 1ns/1ps
`include "mp_defines.svh"

module bank_sram
  import mp_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  bank_cmd_t bank_cmd,
  output data_t     bank_dout
);

  localparam int NUM_ROWS = 2 ** `MP_ROW_BITS;

  data_t                      mem     [NUM_ROWS];
  data_t                      rd_pipe [`MP_SRAM_DELAY];
  logic [`MP_SRAM_DELAY-1:0]  stage_en;
  logic [`MP_SRAM_DELAY-2:0]  vld_q;

  // Stage 0 loads on a read command, later stages follow the valid chain
  assign stage_en = {vld_q, bank_cmd.rd};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= stage_en[`MP_SRAM_DELAY-2:0];
    end
  end

  always_ff @(posedge clk) begin
    if (bank_cmd.wr) begin
      mem[bank_cmd.wr_row] <= bank_cmd.wr_data;
    end
  end

  // Read-first so a same-edge write lands after this sample
  always_ff @(posedge clk) begin
    if (stage_en[0]) begin
      rd_pipe[0] <= mem[bank_cmd.rd_row];
    end
    for (int k = 1; k < `MP_SRAM_DELAY; k++) begin
      if (stage_en[k]) begin
        rd_pipe[k] <= rd_pipe[k-1];
      end
    end
  end

  assign bank_dout = rd_pipe[`MP_SRAM_DELAY-1];

endmodule

// ==== rtl/read_return.sv ====
`timescale 1ns/1ps
`include "mp_defines.svh"

module read_return
  import mp_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  rd_tag_t  rd_tag    [`MP_NUM_RD],
  input  data_t    bank_dout [`MP_NUM_BANKS],
  output rd_resp_t rd_resp   [`MP_NUM_RD]
);

  // Bank pipeline plus one capture stage for the bank words
  localparam int TAG_DEPTH = `MP_RD_LATENCY - 1;

  logic [TAG_DEPTH-1:0]  vld_q       [`MP_NUM_RD];
  paddr_t                padr_q      [`MP_NUM_RD][TAG_DEPTH];
  data_t                 bank_q      [`MP_NUM_BANKS];
  bank_t                 sel_bank    [`MP_NUM_RD];
  logic [`MP_NUM_RD-1:0] resp_vld_q;
  paddr_t                resp_padr_q [`MP_NUM_RD];
  data_t                 resp_data_q [`MP_NUM_RD];

  // Bank of the tag that lines up with bank_q
  always_comb begin
    for (int p = 0; p < `MP_NUM_RD; p++) begin
      sel_bank[p] = padr_q[p][TAG_DEPTH-1][`MP_ROW_BITS +: `MP_BANK_BITS];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int p = 0; p < `MP_NUM_RD; p++) begin
        vld_q[p] <= '0;
      end
      resp_vld_q <= '0;
    end else begin
      for (int p = 0; p < `MP_NUM_RD; p++) begin
        vld_q[p]      <= {vld_q[p][TAG_DEPTH-2:0], rd_tag[p].vld};
        resp_vld_q[p] <= vld_q[p][TAG_DEPTH-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bank_q <= bank_dout;
    for (int p = 0; p < `MP_NUM_RD; p++) begin
      padr_q[p][0] <= rd_tag[p].padr;
      for (int k = 1; k < TAG_DEPTH; k++) begin
        padr_q[p][k] <= padr_q[p][k-1];
      end
      resp_padr_q[p] <= padr_q[p][TAG_DEPTH-1];
      resp_data_q[p] <= bank_q[sel_bank[p]];
    end
  end

  always_comb begin
    for (int p = 0; p < `MP_NUM_RD; p++) begin
      rd_resp[p].vld  = resp_vld_q[p];
      rd_resp[p].padr = resp_padr_q[p];
      rd_resp[p].data = resp_data_q[p];
    end
  end

endmodule

// ==== rtl/mp_mem_top.sv ====
`timescale 1ns/1ps
`include "mp_defines.svh"

module mp_mem_top
  import mp_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  wr_req_t  wr_req  [`MP_NUM_WR],
  input  rd_req_t  rd_req  [`MP_NUM_RD],
  output rd_resp_t rd_resp [`MP_NUM_RD]
);

  bank_cmd_t bank_cmd  [`MP_NUM_BANKS];
  rd_tag_t   rd_tag    [`MP_NUM_RD];
  data_t     bank_dout [`MP_NUM_BANKS];

  // All four ports meet here
  bank_arbiter arb_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .bank_cmd (bank_cmd),
    .rd_tag   (rd_tag)
  );

  for (genvar b = 0; b < `MP_NUM_BANKS; b++) begin : g_bank
    bank_sram sram_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .bank_cmd  (bank_cmd[b]),
      .bank_dout (bank_dout[b])
    );
  end

  read_return ret_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_tag    (rd_tag),
    .bank_dout (bank_dout),
    .rd_resp   (rd_resp)
  );

endmodule

// ==== verification/mp_mem_props.sv ====
`timescale 1ns/1ps
`include "mp_defines.svh"

module mp_mem_props
  import mp_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input wr_req_t   wr_req   [`MP_NUM_WR],
  input rd_req_t   rd_req   [`MP_NUM_RD],
  input bank_cmd_t bank_cmd [`MP_NUM_BANKS],
  input rd_resp_t  rd_resp  [`MP_NUM_RD]
);

  for (genvar p = 0; p < `MP_NUM_RD; p++) begin : g_rd
    a_no_resp_in_reset: assert property (@(posedge clk) !arst_n |-> !rd_resp[p].vld)
      else $error("read port %0d response valid during reset", p);

    // Sampled one edge after the response register loads
    a_resp_has_req: assert property (@(posedge clk) disable iff (!arst_n)
      rd_resp[p].vld |-> $past(rd_req[p].vld, `MP_RD_LATENCY + 1))
      else $error("read port %0d response without a request", p);
  end

  for (genvar b = 0; b < `MP_NUM_BANKS; b++) begin : g_bank
    a_wr_has_req: assert property (@(posedge clk) disable iff (!arst_n)
      bank_cmd[b].wr |-> $past((wr_req[0].vld && wr_req[0].bank == bank_t'(b)) ||
                               (wr_req[1].vld && wr_req[1].bank == bank_t'(b))))
      else $error("bank %0d write command without a write request", b);
  end

  a_one_read_per_bank: assert property (@(posedge clk) disable iff (!arst_n)
    (rd_resp[0].vld && rd_resp[1].vld) |->
      rd_resp[0].padr[`MP_ROW_BITS +: `MP_BANK_BITS] !=
      rd_resp[1].padr[`MP_ROW_BITS +: `MP_BANK_BITS])
    else $error("both read ports served from one bank");

endmodule

// ==== verification/mp_mem_tb.sv ====
`timescale 1ns/1ps
`include "mp_defines.svh"

module mp_mem_tb
  import mp_pkg::*;
;

  // Well above the roughly 700 cycles the tests take
  localparam int MAX_CYCLES = 2000;

  logic     clk;
  logic     arst_n;
  wr_req_t  wr_req  [`MP_NUM_WR];
  rd_req_t  rd_req  [`MP_NUM_RD];
  rd_resp_t rd_resp [`MP_NUM_RD];

  data_t                     model_mem [64];
  rd_resp_t [`MP_NUM_RD-1:0] exp_q [$];
  rd_resp_t [`MP_NUM_RD-1:0] due;
  logic                      due_vld;
  integer                    seed;
  int                        err_count;
  int                        pass_count;
  int                        test_err_start;
  int                        checked;
  int                        cycle_cnt;

  mp_mem_top dut_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .rd_resp (rd_resp)
  );

  bind mp_mem_top mp_mem_props props_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run stopped: no end of tests after %0d cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Reference model reads the array before this edge's writes
  always @(posedge clk) begin
    rd_resp_t [`MP_NUM_RD-1:0] slot;
    if (!arst_n) begin
      exp_q.delete();
      due_vld = 1'b0;
    end else begin
      for (int p = 0; p < `MP_NUM_RD; p++) begin
        slot[p].vld  = rd_req[p].vld;
        slot[p].padr = {rd_req[p].bank, rd_req[p].row};
        slot[p].data = model_mem[slot[p].padr];
      end
      // Port 1 takes the bank when both reads meet there
      if (rd_req[1].vld && rd_req[0].bank == rd_req[1].bank) begin
        slot[0].vld = 1'b0;
      end
      if (exp_q.size() == `MP_RD_LATENCY) begin
        due     = exp_q.pop_front();
        due_vld = 1'b1;
      end
      exp_q.push_back(slot);
      if (wr_req[0].vld && !(wr_req[1].vld && wr_req[0].bank == wr_req[1].bank)) begin
        model_mem[{wr_req[0].bank, wr_req[0].row}] = wr_req[0].data;
      end
      if (wr_req[1].vld) begin
        model_mem[{wr_req[1].bank, wr_req[1].row}] = wr_req[1].data;
      end
    end
  end

  // Outputs are settled half a cycle after the edge
  always @(negedge clk) begin
    if (due_vld) begin
      checked++;
      for (int p = 0; p < `MP_NUM_RD; p++) begin
        if (rd_resp[p].vld !== due[p].vld ||
            (due[p].vld && (rd_resp[p].padr !== due[p].padr ||
                            rd_resp[p].data !== due[p].data))) begin
          $display("[ERROR] %0t: read port %0d got vld=%b padr=%h data=%h, expected %b %h %h",
                   $time, p, rd_resp[p].vld, rd_resp[p].padr, rd_resp[p].data,
                   due[p].vld, due[p].padr, due[p].data);
          err_count++;
        end
      end
    end
  end

  function automatic data_t fill_word(paddr_t a);
    return {a, a[3:0], a} ^ 16'h5a3c;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
    for (int w = 0; w < `MP_NUM_WR; w++) wr_req[w] = '0;
    for (int r = 0; r < `MP_NUM_RD; r++) rd_req[r] = '0;
  endtask

  // One extra cycle lets the last response slot be checked on its negedge
  task automatic end_test(string name);
    repeat (`MP_RD_LATENCY + 2) tick();
    if (err_count == test_err_start) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_count - test_err_start);
    end
    test_err_start = err_count;
  endtask

  initial begin
    logic [31:0] rnd;
    clk = 1'b0;
    arst_n = 1'b0;
    for (int w = 0; w < `MP_NUM_WR; w++) wr_req[w] = '0;
    for (int r = 0; r < `MP_NUM_RD; r++) rd_req[r] = '0;
    seed = 32'h3e78_5460;
    err_count = 0;
    pass_count = 0;
    test_err_start = 0;
    checked = 0;
    cycle_cnt = 0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    for (int i = 0; i < `MP_RD_LATENCY; i++) begin
      @(negedge clk);
      for (int p = 0; p < `MP_NUM_RD; p++) begin
        if (rd_resp[p].vld !== 1'b0) begin
          $display("[ERROR] %0t: read port %0d valid before any response is due", $time, p);
          err_count++;
        end
      end
    end
    end_test("reset");

    for (int a = 0; a < 64; a++) begin
      tick();
      wr_req[a % 2] = {1'b1, paddr_t'(a), fill_word(paddr_t'(a))};
    end
    for (int a = 0; a < 64; a++) begin
      tick();
      rd_req[a % 2] = {1'b1, paddr_t'(a)};
    end
    end_test("fill_readback");

    // Two writes to one bank on different rows
    tick();
    wr_req[0] = {1'b1, 6'h25, 16'hdead};
    wr_req[1] = {1'b1, 6'h29, 16'hbeef};
    tick();
    rd_req[0] = {1'b1, 6'h25};
    tick();
    rd_req[1] = {1'b1, 6'h29};
    end_test("write_conflict");

    tick();
    rd_req[0] = {1'b1, 6'h13};
    rd_req[1] = {1'b1, 6'h1a};
    end_test("read_conflict");

    tick();
    wr_req[0] = {1'b1, 6'h3c, 16'h0f0f};
    rd_req[0] = {1'b1, 6'h3c};
    tick();
    rd_req[1] = {1'b1, 6'h3c};
    end_test("read_write_same_address");

    for (int i = 0; i < 500; i++) begin
      tick();
      for (int p = 0; p < `MP_NUM_RD; p++) begin
        rnd = $random(seed);
        wr_req[p] = {rnd[31], rnd[21:16], rnd[15:0]};
        rnd = $random(seed);
        rd_req[p] = {rnd[30], rnd[5:0]};
      end
    end
    end_test("random_mix");

    $display("%0d tests ok, %0d errors, %0d response slots checked",
             pass_count, err_count, checked);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
rtl/mp_pkg.sv
rtl/bank_arbiter.sv
rtl/bank_sram.sv
rtl/read_return.sv
rtl/mp_mem_top.sv
verification/mp_mem_props.sv
verification/mp_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the banked memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f flist.f --top-module mp_mem_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vmp_mem_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The testbench prints the result on a line of its own
if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
else
  exit 1
fi
